//--- include/kernel_cu_consts.svh
// ------------------------------------------------
// Kernel compute unit constants
// Bus widths, done hold length, requestor count
// ------------------------------------------------

`ifndef KERNEL_CU_CONSTS_SVH
`define KERNEL_CU_CONSTS_SVH

// Word address into the shared memory
`define KCU_ADDR_WIDTH 16
// Memory word and running sum
`define KCU_DATA_WIDTH 32
// Vertex array length and read index
`define KCU_COUNT_WIDTH 16
// Cycles the finished condition must hold before done
`define KCU_DONE_HOLD 8
// Requestors sharing the memory port
`define KCU_NUM_REQUESTORS 2

`endif

//--- logic/kernel_cu_pkg.sv
// ------------------------------------------------
// Kernel compute unit types
// ------------------------------------------------
`default_nettype none

`include "kernel_cu_consts.svh"

package kernel_cu_pkg;

  // Vectors with a meaning
  typedef logic [`KCU_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`KCU_DATA_WIDTH-1:0]  data_t;
  typedef logic [`KCU_COUNT_WIDTH-1:0] count_t;

  // Setup engine FSM
  typedef enum logic [1:0] {
    SETUP_IDLE, SETUP_READ_BASE, SETUP_READ_LENGTH, SETUP_RUN
  } setup_state_t;

  // Worker FSM
  typedef enum logic [2:0] {
    ACC_IDLE, ACC_FETCH, ACC_WAIT, ACC_SETTLE, ACC_DONE
  } accum_state_t;

endpackage : kernel_cu_pkg

`default_nettype wire

//--- logic/mem_req_if.sv
// ------------------------------------------------
// Read request channel, requestor to arbiter
// One outstanding read, ack pulse carries data
// ------------------------------------------------
`default_nettype none

interface mem_req_if;

  // Held stable by the requestor until ack
  logic                 req;
  kernel_cu_pkg::addr_t addr;

  // One-cycle pulse, rdata valid with it
  logic                 ack;
  kernel_cu_pkg::data_t rdata;

  modport requestor (output req, output addr, input ack, input rdata);

  modport arbiter (input req, input addr, output ack, output rdata);

endinterface : mem_req_if

`default_nettype wire

//--- logic/cu_setup.sv
// ------------------------------------------------
// Setup engine
// Takes the descriptor, reads array base and length
// from memory, then starts the worker
// ------------------------------------------------
`default_nettype none

module cu_setup (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  logic                  descriptor_valid,
  input  kernel_cu_pkg::addr_t  descriptor_base,
  output logic                  busy,
  output logic                  accept,
  mem_req_if.requestor          mem,
  output logic                  start,
  output kernel_cu_pkg::addr_t  array_base,
  output kernel_cu_pkg::count_t array_length,
  input  logic                  finished
);
  import kernel_cu_pkg::*;

  setup_state_t state;
  // Registered descriptor word address
  addr_t        desc_base;

  // Busy falls in the same cycle the worker reports finished
  assign busy   = (state != SETUP_IDLE) && !finished;
  // Also tells the worker to drop its old done
  assign accept = descriptor_valid && !busy;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state   <= SETUP_IDLE;
      mem.req <= 1'b0;
      start   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (accept) begin
        // First config word at the descriptor address
        state   <= SETUP_READ_BASE;
        mem.req <= 1'b1;
      end else begin
        case (state)
          SETUP_READ_BASE: begin
            // Request stays up, next address follows
            if (mem.ack) state <= SETUP_READ_LENGTH;
          end
          SETUP_READ_LENGTH: begin
            if (mem.ack) begin
              state   <= SETUP_RUN;
              mem.req <= 1'b0;
              start   <= 1'b1;
            end
          end
          SETUP_RUN: begin
            if (finished) state <= SETUP_IDLE;
          end
          default: state <= SETUP_IDLE;
        endcase
      end
    end
  end

  // ------------------------------------------------
  // Address and config words
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      desc_base <= descriptor_base;
      mem.addr  <= descriptor_base;
    end
    if (state == SETUP_READ_BASE && mem.ack) begin
      array_base <= addr_t'(mem.rdata);
      // Length word sits right after the base word
      mem.addr   <= desc_base + 1'b1;
    end
    if (state == SETUP_READ_LENGTH && mem.ack) begin
      array_length <= count_t'(mem.rdata);
    end
  end

endmodule : cu_setup

`default_nettype wire

//--- logic/cu_accumulate.sv
// ------------------------------------------------
// Vertex sum worker
// Reads the vertex array one word at a time, adds
// it up and raises done after a settle period
// ------------------------------------------------
`default_nettype none

`include "kernel_cu_consts.svh"

module cu_accumulate (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  logic                  accept,
  input  logic                  start,
  input  kernel_cu_pkg::addr_t  array_base,
  input  kernel_cu_pkg::count_t array_length,
  mem_req_if.requestor          mem,
  output logic                  finished,
  output logic                  done,
  output kernel_cu_pkg::data_t  result_sum
);
  import kernel_cu_pkg::*;

  localparam int HOLD_W = $clog2(`KCU_DONE_HOLD + 1);

  accum_state_t      state;
  logic [HOLD_W-1:0] hold_cnt;
  addr_t             base_q;
  count_t            length_q;
  count_t            index;
  count_t            next_index;
  logic              launch;
  logic              last_word;
  logic              hold_met;

  // A new start is taken from IDLE or DONE
  assign launch     = start && (state == ACC_IDLE || state == ACC_DONE);
  assign next_index = index + 1'b1;
  assign last_word  = (next_index == length_q);
  assign hold_met   = (hold_cnt == HOLD_W'(`KCU_DONE_HOLD - 1));

  assign finished = (state == ACC_DONE);
  assign done     = (state == ACC_DONE);

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state    <= ACC_IDLE;
      mem.req  <= 1'b0;
      hold_cnt <= '0;
    end else if (launch) begin
      hold_cnt <= '0;
      // Empty array skips the fetch loop
      state    <= (array_length == '0) ? ACC_SETTLE : ACC_FETCH;
    end else begin
      case (state)
        ACC_FETCH: begin
          mem.req <= 1'b1;
          state   <= ACC_WAIT;
        end
        ACC_WAIT: begin
          if (mem.ack) begin
            mem.req <= 1'b0;
            state   <= last_word ? ACC_SETTLE : ACC_FETCH;
          end
        end
        ACC_SETTLE: begin
          // Pending read restarts the hold
          if (mem.req) hold_cnt <= '0;
          else if (hold_met) state <= ACC_DONE;
          else hold_cnt <= hold_cnt + 1'b1;
        end
        ACC_DONE: begin
          // Next descriptor clears the old done
          if (accept) state <= ACC_IDLE;
        end
        default: state <= ACC_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (launch) begin
      base_q     <= array_base;
      length_q   <= array_length;
      index      <= '0;
      result_sum <= '0;
    end
    if (state == ACC_FETCH) mem.addr <= base_q + index;
    if (state == ACC_WAIT && mem.ack) begin
      // Wraps modulo 2^32
      result_sum <= result_sum + mem.rdata;
      index      <= next_index;
    end
  end

endmodule : cu_accumulate

`default_nettype wire

//--- logic/memory_arbiter.sv
// ------------------------------------------------
// Memory port arbiter
// Fixed priority between setup and worker, one
// Wishbone classic read at a time
// ------------------------------------------------
`default_nettype none

`include "kernel_cu_consts.svh"

module memory_arbiter (
  input  logic                 ap_clk,
  input  logic                 areset_control,
  mem_req_if.arbiter           setup_port,
  mem_req_if.arbiter           accum_port,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output kernel_cu_pkg::addr_t wb_adr,
  input  kernel_cu_pkg::data_t wb_dat_i,
  input  logic                 wb_ack
);
  import kernel_cu_pkg::*;

  logic [`KCU_NUM_REQUESTORS-1:0] req_vec;
  logic [`KCU_NUM_REQUESTORS-1:0] grant_next;
  logic [`KCU_NUM_REQUESTORS-1:0] grant_q;
  logic [`KCU_NUM_REQUESTORS-1:0] ack_q;
  data_t                          rdata_q;
  logic                           arb_idle;

  // Bit 0 is setup and wins ties
  assign req_vec    = {accum_port.req, setup_port.req};
  assign grant_next = req_vec & (~req_vec + 1'b1);

  // Free only once the ack pulse is out, so a held
  // request is never granted twice
  assign arb_idle = !wb_cyc && !(|ack_q);

  // ------------------------------------------------
  // Bus cycle control
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wb_cyc  <= 1'b0;
      wb_stb  <= 1'b0;
      grant_q <= '0;
      ack_q   <= '0;
    end else begin
      ack_q <= '0;
      if (arb_idle && (|req_vec)) begin
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        grant_q <= grant_next;
      end else if (wb_cyc && wb_ack) begin
        // End of cycle, pulse the owner
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        ack_q  <= grant_q;
      end
    end
  end

  // ------------------------------------------------
  // Address and read data
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (arb_idle && (|req_vec)) begin
      wb_adr <= grant_next[0] ? setup_port.addr : accum_port.addr;
    end
    if (wb_cyc && wb_ack) rdata_q <= wb_dat_i;
  end

  // Data goes to both, only the owner sees ack
  assign setup_port.ack   = ack_q[0];
  assign accum_port.ack   = ack_q[1];
  assign setup_port.rdata = rdata_q;
  assign accum_port.rdata = rdata_q;

endmodule : memory_arbiter

`default_nettype wire

//--- logic/kernel_cu.sv
// ------------------------------------------------
// Kernel compute unit top level
// Setup engine, vertex sum worker and a shared
// Wishbone classic read port
// ------------------------------------------------
`default_nettype none

module kernel_cu (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  // Kernel descriptor
  input  logic                  descriptor_valid,
  input  kernel_cu_pkg::addr_t  descriptor_base,
  // Status
  output logic                  busy,
  output logic                  done,
  output kernel_cu_pkg::data_t  result_sum,
  // Wishbone master, read only
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output kernel_cu_pkg::addr_t  wb_adr,
  input  kernel_cu_pkg::data_t  wb_dat_i,
  input  logic                  wb_ack
);
  import kernel_cu_pkg::*;

  // ------------------------------------------------
  // Internal wires
  // ------------------------------------------------
  // Descriptor taken this cycle
  logic   accept;
  // Start path to the worker
  logic   start;
  addr_t  array_base;
  count_t array_length;
  logic   finished;

  // Requestor 0 is setup, requestor 1 is the worker
  mem_req_if setup_req ();
  mem_req_if accum_req ();

  // ------------------------------------------------
  // Input side
  // ------------------------------------------------
  cu_setup u_cu_setup (
    .ap_clk           (ap_clk),
    .areset_control   (areset_control),
    .descriptor_valid (descriptor_valid),
    .descriptor_base  (descriptor_base),
    .busy             (busy),
    .accept           (accept),
    .mem              (setup_req.requestor),
    .start            (start),
    .array_base       (array_base),
    .array_length     (array_length),
    .finished         (finished)
  );

  // ------------------------------------------------
  // Processing part
  // ------------------------------------------------
  cu_accumulate u_cu_accumulate (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .accept         (accept),
    .start          (start),
    .array_base     (array_base),
    .array_length   (array_length),
    .mem            (accum_req.requestor),
    .finished       (finished),
    .done           (done),
    .result_sum     (result_sum)
  );

  // ------------------------------------------------
  // Output side
  // ------------------------------------------------
  memory_arbiter u_memory_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .setup_port     (setup_req.arbiter),
    .accum_port     (accum_req.arbiter),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_adr         (wb_adr),
    .wb_dat_i       (wb_dat_i),
    .wb_ack         (wb_ack)
  );

endmodule : kernel_cu

`default_nettype wire

//--- testbench/kernel_cu_properties.sv
// ------------------------------------------------
// Wishbone and status checks for the kernel unit
// ------------------------------------------------
`default_nettype none

module kernel_cu_properties (
  input logic                 ap_clk,
  input logic                 areset_control,
  input logic                 wb_cyc,
  input logic                 wb_stb,
  input kernel_cu_pkg::addr_t wb_adr,
  input logic                 wb_ack,
  input logic                 busy,
  input logic                 done
);

  // Failure tallies, one per check
  int unsigned stb_fails = 0;
  int unsigned adr_fails = 0;
  int unsigned overlap_fails = 0;

  // Strobe rises and falls with the cycle
  stb_with_cyc: assert property (@(posedge ap_clk) disable iff (areset_control)
    wb_stb == wb_cyc)
    else begin
      $error("wb_stb and wb_cyc differ");
      stb_fails++;
    end

  // Address held until the slave acks
  adr_held: assert property (@(posedge ap_clk) disable iff (areset_control)
    (wb_cyc && !wb_ack) |=> $stable(wb_adr))
    else begin
      $error("wb_adr changed inside a bus cycle");
      adr_fails++;
    end

  // Done only shows once the unit is free
  done_not_busy: assert property (@(posedge ap_clk) disable iff (areset_control)
    !(done && busy))
    else begin
      $error("done and busy high together");
      overlap_fails++;
    end

endmodule : kernel_cu_properties

bind kernel_cu kernel_cu_properties u_props (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .wb_cyc         (wb_cyc),
  .wb_stb         (wb_stb),
  .wb_adr         (wb_adr),
  .wb_ack         (wb_ack),
  .busy           (busy),
  .done           (done)
);

`default_nettype wire

//--- testbench/tb_kernel_cu.sv
// ------------------------------------------------
// Testbench for the kernel compute unit
// Wishbone memory model, random jobs, sum checks
// ------------------------------------------------
`default_nettype none

module tb_kernel_cu;
  import kernel_cu_pkg::*;

  localparam int SEED       = 9;
  localparam int MEM_WORDS  = 1024;
  localparam int NUM_RANDOM = 20;
  localparam int NUM_CHAIN  = 4;
  localparam int MAX_LEN    = 40;
  localparam int WRAP_LEN   = 32;
  // Random, empty, chained, busy pair and wrap descriptors
  localparam int TEST_COUNT  = NUM_RANDOM + NUM_CHAIN + 4;
  localparam int TOTAL_LEN   = MAX_LEN * (NUM_RANDOM + NUM_CHAIN + 1) + WRAP_LEN;
  localparam int CYCLE_LIMIT = TOTAL_LEN * 8 + TEST_COUNT * 200;

  logic  ap_clk;
  logic  areset_control;
  logic  descriptor_valid;
  addr_t descriptor_base;
  logic  busy;
  logic  done;
  data_t result_sum;
  logic  wb_cyc;
  logic  wb_stb;
  addr_t wb_adr;
  data_t wb_dat_i;
  logic  wb_ack;

  data_t mem [0:MEM_WORDS-1];
  // Expected sums in acceptance order
  data_t expected_q [$];
  int    errors = 0;
  int    issued = 0;
  int    done_count = 0;

  kernel_cu u_dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  function automatic logic [9:0] word_at(input int addr);
    return addr[9:0];
  endfunction

  // Config words at dbase, then the array sum modulo 2^32
  function automatic data_t reference_sum(input data_t m [0:MEM_WORDS-1], input int dbase);
    data_t sum;
    int    abase;
    int    len;
    sum   = '0;
    abase = int'(m[word_at(dbase)][15:0]);
    len   = int'(m[word_at(dbase + 1)][15:0]);
    for (int i = 0; i < len; i++) begin
      sum = sum + m[word_at(abase + i)];
    end
    return sum;
  endfunction

  // Descriptor pair at dbase, vertex values at abase
  task automatic load_job(input int dbase, input int abase, input int len, input logic wrap);
    mem[word_at(dbase)]     = data_t'(abase);
    mem[word_at(dbase + 1)] = data_t'(len);
    for (int i = 0; i < len; i++) begin
      mem[word_at(abase + i)] = wrap ? ($urandom() | 32'h8000_0000) : $urandom();
    end
  endtask

  // Unit must be free when called
  task automatic issue_descriptor(input int dbase);
    @(posedge ap_clk);
    descriptor_valid <= 1'b1;
    descriptor_base  <= addr_t'(dbase);
    expected_q.push_back(reference_sum(mem, dbase));
    issued++;
    @(posedge ap_clk);
    descriptor_valid <= 1'b0;
    // Busy up and old done gone one cycle after acceptance
    @(negedge ap_clk);
    assert (busy && !done)
      else begin
        $display("Error at %0t: busy %b done %b after descriptor %0d", $time, busy, done, dbase);
        errors++;
      end
  endtask

  task automatic wait_done();
    @(negedge ap_clk);
    while (!done) @(negedge ap_clk);
  endtask

  // ------------------------------------------------
  // Wishbone memory, 0 to 3 wait cycles per read
  // ------------------------------------------------
  initial begin : memory_model
    int ack_wait;
    wb_ack   = 1'b0;
    wb_dat_i = '0;
    ack_wait = -1;
    forever begin
      @(posedge ap_clk);
      if (wb_ack || areset_control) begin
        wb_ack   <= 1'b0;
        ack_wait = -1;
      end else if (wb_cyc && wb_stb) begin
        if (ack_wait < 0) ack_wait = int'($urandom() % 4);
        if (ack_wait == 0) begin
          wb_ack   <= 1'b1;
          wb_dat_i <= mem[wb_adr[9:0]];
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
    end
  end

  // ------------------------------------------------
  // Compare on each rising done
  // ------------------------------------------------
  initial begin : compare_results
    logic  done_q;
    data_t expected;
    done_q = 1'b0;
    forever begin
      @(negedge ap_clk);
      if (done === 1'b1 && !done_q) begin
        done_count++;
        assert (expected_q.size() > 0)
          else begin
            $display("Done rose at %0t with no descriptor outstanding", $time);
            errors++;
          end
        if (expected_q.size() > 0) begin
          expected = expected_q.pop_front();
          assert (result_sum === expected)
            else begin
              $display("Error at %0t: result_sum %h, expected %h", $time, result_sum, expected);
              errors++;
            end
        end
      end
      done_q = (done === 1'b1);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge ap_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin : stimulus
    int dbase;
    int abase;
    int prop_fails;
    void'($urandom(SEED));
    areset_control   = 1'b1;
    descriptor_valid = 1'b0;
    descriptor_base  = '0;
    // Background pattern from the full word address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[word_at(i)] = {16'hC0DE, 6'd0, word_at(i)};
    end
    repeat (10) @(posedge ap_clk);
    areset_control <= 1'b0;

    // Random jobs, descriptors below 128, arrays above
    for (int t = 0; t < NUM_RANDOM; t++) begin
      dbase = 2 * int'($urandom() % 64);
      abase = 128 + int'($urandom() % (MEM_WORDS - 128 - MAX_LEN));
      load_job(dbase, abase, 1 + int'($urandom() % MAX_LEN), 1'b0);
      issue_descriptor(dbase);
      wait_done();
    end

    // Empty array
    load_job(0, 200, 0, 1'b0);
    issue_descriptor(0);
    wait_done();

    // Chained jobs in disjoint regions, next one right at done
    for (int t = 0; t < NUM_CHAIN; t++) begin
      load_job(2 * t, 128 + 200 * t, 1 + int'($urandom() % MAX_LEN), 1'b0);
    end
    for (int t = 0; t < NUM_CHAIN; t++) begin
      issue_descriptor(2 * t);
      wait_done();
    end

    // Second descriptor shown only while busy
    load_job(20, 300, MAX_LEN, 1'b0);
    load_job(22, 600, 5, 1'b0);
    issue_descriptor(20);
    @(posedge ap_clk);
    descriptor_valid <= 1'b1;
    descriptor_base  <= addr_t'(22);
    repeat (3) @(posedge ap_clk);
    descriptor_valid <= 1'b0;
    wait_done();
    repeat (50) @(negedge ap_clk);
    assert (done && !busy)
      else begin
        $display("The unit left done at %0t without an accepted descriptor", $time);
        errors++;
      end

    // Top bit set in every word, sum wraps
    load_job(40, 700, WRAP_LEN, 1'b1);
    issue_descriptor(40);
    wait_done();

    repeat (2) @(negedge ap_clk);
    assert (done_count == issued && expected_q.size() == 0)
      else begin
        $display("Saw %0d done pulses for %0d accepted descriptors", done_count, issued);
        errors++;
      end
    prop_fails = u_dut.u_props.stb_fails + u_dut.u_props.adr_fails
               + u_dut.u_props.overlap_fails;
    $display("Summary: %0d descriptors, %0d check errors, %0d assertion failures",
             issued, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_kernel_cu

`default_nettype wire

//--- build.f
+incdir+include
logic/kernel_cu_pkg.sv
logic/mem_req_if.sv
logic/cu_setup.sv
logic/cu_accumulate.sv
logic/memory_arbiter.sv
logic/kernel_cu.sv
testbench/kernel_cu_properties.sv
testbench/tb_kernel_cu.sv

//--- run_sim.sh
#!/bin/sh
# Build the kernel compute unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_kernel_cu -o sim_kernel_cu

# Let the testbench reach its summary even after assertion errors
status=0
./obj_dir/sim_kernel_cu +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit "$status"
fi
echo "Simulation passed"
